// ==== dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////

// Data word width
`define DC_WORD_W 32
// Tag bits left over after index, block and byte offset
`define DC_TAG_W 26
// Set index bits
`define DC_IDX_W 3
// Two ways per set
`define DC_SETS 8
`define DC_FRAMES 16

`endif

// ==== dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

	// One data word
	typedef logic [`DC_WORD_W-1:0] word_t;

	// Byte address split into cache fields
	typedef struct packed {
		logic [`DC_TAG_W-1:0] tag;
		logic [`DC_IDX_W-1:0] idx;
		logic blkoff;
		logic [1:0] byteoff;
	} dc_addr_t;

	// Frame number is set index then way bit
	typedef logic [`DC_IDX_W:0] frame_t;

	// Controller states
	typedef enum logic [3:0] {
		IDLE,
		WB1,
		WB2,
		FD1,
		FD2,
		FL_CHK,
		FL_WB1,
		FL_WB2,
		FLUSHED
	} fsm_state_t;

endpackage

// ==== cache_ctrl_if.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

interface cache_ctrl_if;

	// Strobes and selects from the controller
	logic fill_en;
	logic fill_last;
	logic word_sel;
	logic wb_src_flush;
	logic clean_en;

	// Lookup results from the tag arrays
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_needs_wb;
	logic [`DC_TAG_W-1:0] wb_tag;
	logic frame_dirty;

	modport fsm (
		output fill_en, fill_last, word_sel, wb_src_flush, clean_en,
		input hit, victim_needs_wb, frame_dirty
	);

	modport tags (
		input fill_last, clean_en, wb_src_flush,
		output hit, hit_way, victim_way, victim_needs_wb, wb_tag, frame_dirty
	);

	modport data (
		input fill_en, word_sel, wb_src_flush, hit_way, victim_way, victim_needs_wb, wb_tag
	);

endinterface

// ==== dcache_fsm.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_fsm import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic cpu_valid,
	input logic cpu_write,
	input logic halt,
	input logic mem_wait,
	output logic cpu_ready,
	output logic mem_ren,
	output logic mem_wen,
	output logic flushed,
	output logic cnt_step,
	output logic cnt_clear,
	input logic cnt_last,
	cache_ctrl_if.fsm ctrl
);

	fsm_state_t state;
	fsm_state_t next_state;
	logic miss;
	logic mem_done;

	// Request present but not in the cache
	assign miss = cpu_valid && !ctrl.hit;
	// Current memory beat finishes this cycle
	assign mem_done = !mem_wait;

	// Hits complete in IDLE only, and halt takes priority over a pending request
	assign cpu_ready = (state == IDLE) && ctrl.hit && !halt;

	////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (halt) begin
					next_state = FL_CHK;
				end else if (miss) begin
					// Dirty victim goes out before the new block comes in
					next_state = ctrl.victim_needs_wb ? WB1 : FD1;
				end
			end
			WB1: if (mem_done) next_state = WB2;
			WB2: if (mem_done) next_state = FD1;
			FD1: if (mem_done) next_state = FD2;
			// Back to IDLE where the request now hits
			FD2: if (mem_done) next_state = IDLE;
			FL_CHK: begin
				if (ctrl.frame_dirty) begin
					next_state = FL_WB1;
				end else if (cnt_last) begin
					next_state = FLUSHED;
				end
			end
			FL_WB1: if (mem_done) next_state = FL_WB2;
			FL_WB2: begin
				if (mem_done) begin
					next_state = cnt_last ? FLUSHED : FL_CHK;
				end
			end
			// Held until reset
			FLUSHED: next_state = FLUSHED;
			default: next_state = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output decode
	////////////////////////////////////////////////////////////
	always_comb begin
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		ctrl.word_sel = 1'b0;
		ctrl.fill_en = 1'b0;
		ctrl.fill_last = 1'b0;
		ctrl.clean_en = 1'b0;
		cnt_step = 1'b0;
		// Flush mode also blocks tag updates from a request left pending under halt
		ctrl.wb_src_flush = (state == IDLE) ? halt : (state >= FL_CHK);
		// Counter restarts at frame 0 on the way into the flush
		cnt_clear = (state == IDLE) && halt;
		flushed = (state == FLUSHED);
		case (state)
			WB1: mem_wen = 1'b1;
			WB2: begin
				mem_wen = 1'b1;
				ctrl.word_sel = 1'b1;
				// Victim is clean once its second word is accepted
				ctrl.clean_en = mem_done;
			end
			FD1: begin
				mem_ren = 1'b1;
				ctrl.fill_en = mem_done;
			end
			FD2: begin
				mem_ren = 1'b1;
				ctrl.word_sel = 1'b1;
				ctrl.fill_en = mem_done;
				ctrl.fill_last = mem_done;
			end
			// Clean frame is done in one cycle
			FL_CHK: cnt_step = !ctrl.frame_dirty;
			FL_WB1: mem_wen = 1'b1;
			FL_WB2: begin
				mem_wen = 1'b1;
				ctrl.word_sel = 1'b1;
				ctrl.clean_en = mem_done;
				cnt_step = mem_done;
			end
			default: begin
				mem_ren = 1'b0;
			end
		endcase
	end

endmodule

// ==== frame_counter.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module frame_counter import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic step,
	input logic clear,
	output frame_t frame,
	output logic last
);

	frame_t count_q;

	////////////////////////////////////////////////////////////
	// Flush walk counter
	////////////////////////////////////////////////////////////

	// Walks frames 0 to 15 as set index then way
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			count_q <= '0;
		end else if (clear) begin
			// Flush starts at frame 0
			count_q <= '0;
		end else if (step) begin
			// Wraps after the last frame, unused by then
			count_q <= count_q + frame_t'(1);
		end
	end

	assign frame = count_q;

	// Final frame of the walk
	assign last = (count_q == frame_t'(`DC_FRAMES - 1));

endmodule

// ==== tag_store.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module tag_store import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic cpu_valid,
	input logic cpu_write,
	input dc_addr_t cpu_addr,
	input frame_t flush_frame,
	cache_ctrl_if.tags ctrl
);

	// Per frame status and tag
	logic [`DC_FRAMES-1:0] valid_q;
	logic [`DC_FRAMES-1:0] dirty_q;
	logic [`DC_TAG_W-1:0] tag_q [`DC_FRAMES];
	// One bit per set, names the way to replace next
	logic [`DC_SETS-1:0] lru_q;

	frame_t way0_f;
	frame_t way1_f;
	frame_t hit_f;
	frame_t victim_f;
	frame_t wb_f;
	logic match0;
	logic match1;
	logic accept;

	////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////
	assign way0_f = {cpu_addr.idx, 1'b0};
	assign way1_f = {cpu_addr.idx, 1'b1};

	// Tag compare on both ways of the set
	assign match0 = valid_q[way0_f] && (tag_q[way0_f] == cpu_addr.tag);
	assign match1 = valid_q[way1_f] && (tag_q[way1_f] == cpu_addr.tag);

	assign ctrl.hit = cpu_valid && (match0 || match1);
	// A tag lives in at most one way
	assign ctrl.hit_way = match1;
	assign hit_f = {cpu_addr.idx, match1};

	// Victim straight from LRU
	assign ctrl.victim_way = lru_q[cpu_addr.idx];
	assign victim_f = {cpu_addr.idx, lru_q[cpu_addr.idx]};
	// Goes low after WB2 cleans the frame
	assign ctrl.victim_needs_wb = valid_q[victim_f] && dirty_q[victim_f];

	// Write-back frame is the flush frame or the victim
	assign wb_f = ctrl.wb_src_flush ? flush_frame : victim_f;
	assign ctrl.wb_tag = tag_q[wb_f];

	assign ctrl.frame_dirty = valid_q[flush_frame] && dirty_q[flush_frame];

	// Same condition as cpu_ready in the controller
	assign accept = ctrl.hit && !ctrl.wb_src_flush;

	////////////////////////////////////////////////////////////
	// Status and LRU update
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end else begin
			if (accept) begin
				// Other way becomes least recently used
				lru_q[cpu_addr.idx] <= ~ctrl.hit_way;
				if (cpu_write) begin
					dirty_q[hit_f] <= 1'b1;
				end
			end
			if (ctrl.clean_en) begin
				dirty_q[wb_f] <= 1'b0;
			end
			// New block arrives clean
			if (ctrl.fill_last) begin
				valid_q[victim_f] <= 1'b1;
				dirty_q[victim_f] <= 1'b0;
			end
		end
	end

	// Tag written with the second fill word
	always_ff @(posedge CLK) begin
		if (ctrl.fill_last) begin
			tag_q[victim_f] <= cpu_addr.tag;
		end
	end

endmodule

// ==== data_store.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module data_store import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input dc_addr_t cpu_addr,
	input word_t cpu_wdata,
	input logic cpu_wr_hit,
	input word_t mem_rdata,
	input frame_t flush_frame,
	output word_t cpu_rdata,
	output dc_addr_t mem_addr,
	output word_t mem_wdata,
	cache_ctrl_if.data ctrl
);

	// Two words per frame
	word_t words_q [`DC_FRAMES][2];

	frame_t hit_f;
	frame_t victim_f;
	frame_t wb_f;

	assign hit_f = {cpu_addr.idx, ctrl.hit_way};
	assign victim_f = {cpu_addr.idx, ctrl.victim_way};
	assign wb_f = ctrl.wb_src_flush ? flush_frame : victim_f;

	// Read mux toward the processor
	assign cpu_rdata = words_q[hit_f][cpu_addr.blkoff];

	// Store data from the frame being written back
	assign mem_wdata = words_q[wb_f][ctrl.word_sel];

	////////////////////////////////////////////////////////////
	// Memory address
	////////////////////////////////////////////////////////////
	always_comb begin
		mem_addr.byteoff = 2'b00;
		mem_addr.blkoff = ctrl.word_sel;
		mem_addr.idx = ctrl.wb_src_flush ? flush_frame[`DC_IDX_W:1] : cpu_addr.idx;
		// Stored tag for a write-back, request tag for a fill
		if (ctrl.wb_src_flush || ctrl.victim_needs_wb) begin
			mem_addr.tag = ctrl.wb_tag;
		end else begin
			mem_addr.tag = cpu_addr.tag;
		end
	end

	// Write mux
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			words_q <= '{default: '0};
		end else if (cpu_wr_hit) begin
			words_q[hit_f][cpu_addr.blkoff] <= cpu_wdata;
		end else if (ctrl.fill_en) begin
			// Fill lands in the victim frame
			words_q[victim_f][ctrl.word_sel] <= mem_rdata;
		end
	end

endmodule

// ==== dcache.sv ====
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	// Processor side
	input logic cpu_valid,
	input logic cpu_write,
	input dc_addr_t cpu_addr,
	input word_t cpu_wdata,
	output logic cpu_ready,
	output word_t cpu_rdata,
	input logic halt,
	output logic flushed,
	// Memory side
	output logic mem_ren,
	output logic mem_wen,
	output dc_addr_t mem_addr,
	output word_t mem_wdata,
	input word_t mem_rdata,
	input logic mem_wait
);

	cache_ctrl_if ctrl_bus ();

	logic cnt_step;
	logic cnt_clear;
	logic cnt_last;
	frame_t flush_frame;
	logic cpu_wr_hit;

	// Accepted write
	assign cpu_wr_hit = cpu_ready && cpu_write;

	////////////////////////////////////////////////////////////
	// Controller and flush walk
	////////////////////////////////////////////////////////////
	dcache_fsm u_fsm (
		.CLK(CLK),
		.nRST(nRST),
		.cpu_valid(cpu_valid),
		.cpu_write(cpu_write),
		.halt(halt),
		.mem_wait(mem_wait),
		.cpu_ready(cpu_ready),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.flushed(flushed),
		.cnt_step(cnt_step),
		.cnt_clear(cnt_clear),
		.cnt_last(cnt_last),
		.ctrl(ctrl_bus.fsm)
	);

	frame_counter u_frame_counter (
		.CLK(CLK),
		.nRST(nRST),
		.step(cnt_step),
		.clear(cnt_clear),
		.frame(flush_frame),
		.last(cnt_last)
	);

	////////////////////////////////////////////////////////////
	// Arrays
	////////////////////////////////////////////////////////////
	tag_store u_tag_store (
		.CLK(CLK),
		.nRST(nRST),
		.cpu_valid(cpu_valid),
		.cpu_write(cpu_write),
		.cpu_addr(cpu_addr),
		.flush_frame(flush_frame),
		.ctrl(ctrl_bus.tags)
	);

	data_store u_data_store (
		.CLK(CLK),
		.nRST(nRST),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_wr_hit(cpu_wr_hit),
		.mem_rdata(mem_rdata),
		.flush_frame(flush_frame),
		.cpu_rdata(cpu_rdata),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.ctrl(ctrl_bus.data)
	);

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/100ps

module tb_mem_model import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic mem_ren,
	input logic mem_wen,
	input dc_addr_t mem_addr,
	input word_t mem_wdata,
	output word_t mem_rdata,
	output logic mem_wait
);

	// 256 words, byte address bits 9 to 2
	word_t mem [256];
	logic wait_q = 1'b1;
	logic fresh = 1'b1;
	int left = 0;

	assign mem_rdata = mem[mem_addr[9:2]];
	assign mem_wait = wait_q;

	initial begin
		for (int i = 0; i < 256; i++) begin
			// Pattern depends on every bit of the word address
			mem[i] = 32'hC0DE_0000 ^ (i * 32'h0101_0137);
		end
	end

	////////////////////////////////////////////////////////////
	// Wait states, 0 to 3 per beat, changed on the falling edge
	////////////////////////////////////////////////////////////
	always @(negedge CLK, negedge nRST) begin
		int n;
		if (!nRST) begin
			wait_q <= 1'b1;
			fresh <= 1'b1;
			left <= 0;
		end else if (mem_ren || mem_wen) begin
			// New beat draws its own wait count
			n = fresh ? int'($urandom % 4) : left;
			if (n == 0) begin
				wait_q <= 1'b0;
				fresh <= 1'b1;
			end else begin
				wait_q <= 1'b1;
				left <= n - 1;
				fresh <= 1'b0;
			end
		end else begin
			wait_q <= 1'b1;
			fresh <= 1'b1;
		end
	end

	// Store accepted on the rising edge of the last cycle
	always @(posedge CLK) begin
		if (mem_wen && !mem_wait) begin
			mem[mem_addr[9:2]] <= mem_wdata;
		end
	end

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/100ps

module tb_dcache import dcache_pkg::*; ();

	// Operations over all tests, sizes the watchdog
	localparam int num_ops = 240;

	logic CLK = 1'b0;
	logic nRST;
	logic cpu_valid;
	logic cpu_write;
	dc_addr_t cpu_addr;
	word_t cpu_wdata;
	logic cpu_ready;
	word_t cpu_rdata;
	logic halt;
	logic flushed;
	logic mem_ren;
	logic mem_wen;
	dc_addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_wait;

	// Last value written per word, starts as the memory pattern
	word_t shadow [256];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	int errors_at_start = 0;
	int read_beats = 0;

	dcache uut (.*);

	tb_mem_model u_mem (.*);

	always #4 CLK = ~CLK;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic word_t init_word(input int i);
		return 32'hC0DE_0000 ^ (i * 32'h0101_0137);
	endfunction

	function automatic word_t ref_read(input logic [31:0] addr);
		return shadow[addr[9:2]];
	endfunction

	function automatic logic [31:0] make_addr(input int tag, input int idx, input int blk);
		return (tag << 6) | (idx << 3) | (blk << 2);
	endfunction

	// 32 words spread over sets and tags
	function automatic logic [31:0] pick_addr();
		return ((($urandom % 32) * 7) << 2);
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != errors_at_start) begin
			failed++;
			$display("Test %s: failed with %0d errors", name, errors - errors_at_start);
		end else begin
			$display("Test %s: passed", name);
		end
	endtask

	task automatic pulse_reset();
		@(negedge CLK);
		nRST = 1'b0;
		repeat (2) @(negedge CLK);
		nRST = 1'b1;
	endtask

	// One request, held until the handshake edge
	task automatic cpu_access(input logic wr, input logic [31:0] addr, input word_t wdata);
		@(negedge CLK);
		cpu_valid = 1'b1;
		cpu_write = wr;
		cpu_addr = addr;
		cpu_wdata = wdata;
		@(posedge CLK);
		while (!cpu_ready) begin
			@(posedge CLK);
		end
		@(negedge CLK);
		cpu_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Compare process on each accepted request
	////////////////////////////////////////////////////////////
	always @(posedge CLK) begin
		if (nRST && cpu_valid && cpu_ready) begin
			if (cpu_write) begin
				shadow[cpu_addr[9:2]] = cpu_wdata;
			end else begin
				check("cpu_rdata", ref_read(cpu_addr), cpu_rdata);
			end
		end
	end

	// Completed memory reads, for the LRU test
	always @(posedge CLK) begin
		if (mem_ren && !mem_wait) begin
			read_beats++;
		end
	end

	// Watchdog
	initial begin
		#((num_ops * 24 + 16 * 12) * 8);
		$display("Run timed out at %0t before all tests finished", $time);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] a;
		int beats;
		void'($urandom(34));
		for (int i = 0; i < 256; i++) begin
			shadow[i] = init_word(i);
		end
		nRST = 1'b0;
		cpu_valid = 1'b0;
		cpu_write = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		halt = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;

		// Miss fills the block, second read hits
		start_test();
		a = make_addr(2, 1, 0);
		cpu_access(1'b0, a, '0);
		cpu_access(1'b0, a, '0);
		end_test("read miss then hit");

		start_test();
		cpu_access(1'b1, a, 32'h1234_5678);
		cpu_access(1'b0, a, '0);
		check("u_mem.mem", init_word(a[9:2]), u_mem.mem[a[9:2]]);
		end_test("write hit");

		// Third tag in set 5 pushes out the dirty block
		start_test();
		a = make_addr(3, 5, 1);
		cpu_access(1'b1, a, 32'hDEAD_BEEF);
		cpu_access(1'b0, make_addr(4, 5, 0), '0);
		cpu_access(1'b0, make_addr(6, 5, 0), '0);
		check("u_mem.mem", 32'hDEAD_BEEF, u_mem.mem[a[9:2]]);
		end_test("dirty eviction");

		start_test();
		cpu_access(1'b0, make_addr(1, 2, 0), '0);
		cpu_access(1'b0, make_addr(7, 2, 0), '0);
		cpu_access(1'b0, make_addr(1, 2, 1), '0);
		cpu_access(1'b0, make_addr(9, 2, 0), '0);
		beats = read_beats;
		cpu_access(1'b0, make_addr(1, 2, 0), '0);
		check("read beats after A", beats, read_beats);
		// B was the one replaced, so it needs a fill
		cpu_access(1'b0, make_addr(7, 2, 0), '0);
		check("read beats after B", beats + 2, read_beats);
		end_test("lru");

		start_test();
		repeat (24) begin
			cpu_access(1'b1, pick_addr(), $urandom);
		end
		@(negedge CLK);
		halt = 1'b1;
		@(posedge CLK);
		while (!flushed) begin
			@(posedge CLK);
		end
		repeat (4) begin
			@(negedge CLK);
			check("flushed", 1'b1, flushed);
		end
		for (int i = 0; i < 256; i++) begin
			check($sformatf("u_mem.mem[%0d]", i), shadow[i], u_mem.mem[i]);
		end
		halt = 1'b0;
		pulse_reset();
		end_test("flush");

		// Cache restarts empty over the flushed memory
		start_test();
		repeat (200) begin
			cpu_access(1'($urandom % 2), pick_addr(), $urandom);
		end
		end_test("random mix");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
dcache_pkg.sv
cache_ctrl_if.sv
dcache_fsm.sv
frame_counter.sv
tag_store.sv
data_store.sv
dcache.sv
tb_mem_model.sv
tb_dcache.sv
